//--- hdl/rename_pkg.sv
package rename_pkg;

    // group size and register file sizes
    localparam int rename_width = 2;
    localparam int arch_regs    = 32;
    localparam int phys_regs    = 64;

    // registers not held by the map sit in the free list
    localparam int free_regs     = phys_regs - arch_regs;
    localparam int free_ptr_bits = $clog2(free_regs);

    typedef logic [4:0] arch_reg_idx;
    typedef logic [5:0] phys_reg_idx;

    typedef logic [free_ptr_bits-1:0] free_ptr;
    typedef logic [free_ptr_bits:0]   free_count; // 0 to free_regs inclusive

    typedef struct packed {
        phys_reg_idx phys;
        logic        ready;
    } map_entry;

    typedef struct packed {
        logic        valid;
        logic        has_dest;
        arch_reg_idx dest;
        arch_reg_idx src1;
        arch_reg_idx src2;
    } rename_req;

    typedef struct packed {
        logic        valid;
        phys_reg_idx dest_phys;
        phys_reg_idx t_old;      // previous mapping of dest, freed at retire
        phys_reg_idx src1_phys;
        logic        src1_ready;
        phys_reg_idx src2_phys;
        logic        src2_ready;
    } rename_resp;

endpackage

//--- hdl/cdb_pkg.sv
package cdb_pkg;

    // execution units sharing the broadcast bus
    localparam int fu_count    = 3;
    localparam int cdb_lanes   = 2;
    localparam int fu_idx_bits = $clog2(fu_count);

    typedef logic [fu_idx_bits-1:0] fu_idx;

    // one completion tag, also used as a unit's request
    typedef struct packed {
        logic                    valid;
        rename_pkg::phys_reg_idx tag;
    } cdb_packet;

endpackage

//--- hdl/map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  rename_pkg::rename_req   [rename_pkg::rename_width-1:0] rename_in,
    input  rename_pkg::phys_reg_idx [rename_pkg::rename_width-1:0] new_phys,
    input  logic                                                    accept,
    input  cdb_pkg::cdb_packet      [cdb_pkg::cdb_lanes-1:0]       cdb,
    output rename_pkg::rename_resp  [rename_pkg::rename_width-1:0] rename_out
);
    import rename_pkg::*;
    import cdb_pkg::*;

    map_entry [arch_regs-1:0] entries;
    map_entry [arch_regs-1:0] woken;   // entries with this cycle's broadcasts applied
    map_entry [arch_regs-1:0] renamed; // woken plus the group's new mappings

    // wake-up first so lookups in this cycle already see it
    always_comb begin
        woken = entries;
        for (int r = 0; r < arch_regs; r++) begin
            for (int c = 0; c < cdb_lanes; c++) begin
                if (cdb[c].valid && entries[r].phys == cdb[c].tag) begin
                    woken[r].ready = 1'b1;
                end
            end
        end
    end

    // lane order gives the group bypass for free
    always_comb begin
        renamed = woken;
        for (int i = 0; i < rename_width; i++) begin
            rename_out[i].valid      = rename_in[i].valid && accept;
            rename_out[i].dest_phys  = new_phys[i];
            rename_out[i].src1_phys  = renamed[rename_in[i].src1].phys;
            rename_out[i].src1_ready = renamed[rename_in[i].src1].ready;
            rename_out[i].src2_phys  = renamed[rename_in[i].src2].phys;
            rename_out[i].src2_ready = renamed[rename_in[i].src2].ready;
            rename_out[i].t_old      = renamed[rename_in[i].dest].phys; // lane 0's tag if same dest

            // sources read before own dest is overwritten
            if (rename_in[i].valid && rename_in[i].has_dest) begin
                renamed[rename_in[i].dest].phys  = new_phys[i];
                renamed[rename_in[i].dest].ready = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, all ready
            for (int r = 0; r < arch_regs; r++) begin
                entries[r].phys  <= phys_reg_idx'(r);
                entries[r].ready <= 1'b1;
            end
        end else if (accept) begin
            entries <= renamed;
        end else begin
            entries <= woken; // stalled group, broadcasts still land
        end
    end

endmodule

//--- hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  rename_pkg::rename_req   [rename_pkg::rename_width-1:0] rename_in,
    input  logic                    [rename_pkg::rename_width-1:0] retire_valid,
    input  rename_pkg::phys_reg_idx [rename_pkg::rename_width-1:0] retire_phys,
    output rename_pkg::phys_reg_idx [rename_pkg::rename_width-1:0] new_phys,
    output logic                                                    accept,
    output logic                                                    rename_stall
);
    import rename_pkg::*;

    phys_reg_idx [free_regs-1:0]    slots;
    free_ptr                        head;
    free_ptr                        tail;
    free_count                      count;
    logic        [rename_width-1:0] ret_valid_q; // retire stage, pushed a cycle later
    phys_reg_idx [rename_width-1:0] ret_phys_q;
    logic        [1:0]              need;
    logic        [1:0]              push_cnt;
    free_ptr     [rename_width-1:0] push_slot;

    // lanes with a dest take consecutive head entries
    always_comb begin
        need = '0;
        for (int i = 0; i < rename_width; i++) begin
            new_phys[i] = slots[head + free_ptr'(need)];
            if (rename_in[i].valid && rename_in[i].has_dest) begin
                need = need + 2'd1;
            end
        end
    end

    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < rename_width; i++) begin
            push_slot[i] = tail + free_ptr'(push_cnt);
            if (ret_valid_q[i]) begin
                push_cnt = push_cnt + 2'd1;
            end
        end
    end

    assign accept       = count >= free_count'(need);
    assign rename_stall = !accept;

    always_ff @(posedge clock) begin
        ret_phys_q <= retire_phys;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= free_count'(free_regs);
            ret_valid_q <= '0;
            for (int i = 0; i < free_regs; i++) begin
                slots[i] <= phys_reg_idx'(arch_regs + i); // 32..63 in order
            end
        end else begin
            ret_valid_q <= retire_valid;
            if (accept) begin
                head <= head + free_ptr'(need);
            end
            tail  <= tail + free_ptr'(push_cnt);
            count <= count - (accept ? free_count'(need) : '0) + free_count'(push_cnt);
            for (int i = 0; i < rename_width; i++) begin
                if (ret_valid_q[i]) slots[push_slot[i]] <= ret_phys_q[i];
            end
        end
    end

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int latency = 1 // 1 to 4 stages
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  rename_pkg::phys_reg_idx issue_tag,
    output logic                    issue_ready,
    output cdb_pkg::cdb_packet      request,
    input  logic                    grant
);
    import cdb_pkg::*;

    cdb_packet [latency-1:0] stage;   // stage latency-1 is the head
    cdb_packet [latency-1:0] feed;    // what each slot loads when it moves
    logic      [latency-1:0] advance;

    // a slot may load if it is empty or its occupant moves on
    always_comb begin
        advance[latency-1] = !stage[latency-1].valid || grant;
        for (int k = latency - 2; k >= 0; k--) begin
            advance[k] = !stage[k].valid || advance[k+1];
        end
    end

    always_comb begin
        feed[0].valid = issue_valid;
        feed[0].tag   = issue_tag;
        for (int k = 1; k < latency; k++) begin
            feed[k] = stage[k-1]; // bubbles move too, which compacts the pipe
        end
    end

    assign issue_ready = advance[0];
    assign request     = stage[latency-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            stage <= '0;
        end else begin
            for (int k = 0; k < latency; k++) begin
                if (advance[k]) begin
                    stage[k] <= feed[k];
                end
            end
        end
    end

endmodule

//--- hdl/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                                        clock,
    input  logic                                        reset,
    input  cdb_pkg::cdb_packet [cdb_pkg::fu_count-1:0]  request,
    output logic               [cdb_pkg::fu_count-1:0]  grant,
    output cdb_pkg::cdb_packet [cdb_pkg::cdb_lanes-1:0] cdb
);
    import cdb_pkg::*;

    fu_idx ptr;      // first unit considered this cycle
    fu_idx ptr_next;

    always_comb begin
        int unsigned idx;
        int unsigned used;

        grant    = '0;
        cdb      = '0;
        ptr_next = ptr;
        used     = 0;
        for (int i = 0; i < fu_count; i++) begin
            idx = (int'(ptr) + i) % fu_count;
            if (request[idx].valid && used < cdb_lanes) begin
                grant[idx] = 1'b1;
                cdb[used]  = request[idx]; // lanes filled in scan order
                used       = used + 1;
                ptr_next   = fu_idx'((idx + 1) % fu_count); // past the last winner
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else begin
            ptr <= ptr_next;
        end
    end

endmodule

//--- hdl/rename_top.sv
`timescale 1ns/1ps

module rename_top (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  rename_pkg::rename_req   [rename_pkg::rename_width-1:0] rename_in,
    input  logic                    [rename_pkg::rename_width-1:0] retire_valid,
    input  rename_pkg::phys_reg_idx [rename_pkg::rename_width-1:0] retire_phys,
    input  logic                    [cdb_pkg::fu_count-1:0]        issue_valid,
    input  rename_pkg::phys_reg_idx [cdb_pkg::fu_count-1:0]        issue_tag,
    output rename_pkg::rename_resp  [rename_pkg::rename_width-1:0] rename_out,
    output logic                                                    rename_stall,
    output logic                    [cdb_pkg::fu_count-1:0]        issue_ready,
    output cdb_pkg::cdb_packet      [cdb_pkg::cdb_lanes-1:0]       cdb
);
    import rename_pkg::*;
    import cdb_pkg::*;

    phys_reg_idx [rename_width-1:0] new_phys;
    logic                           accept;
    cdb_packet   [fu_count-1:0]     unit_req;   // pipe heads
    logic        [fu_count-1:0]     unit_grant;

    map_table u_map_table (
        .clock      (clock),
        .reset      (reset),
        .rename_in  (rename_in),
        .new_phys   (new_phys),
        .accept     (accept),
        .cdb        (cdb),
        .rename_out (rename_out)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .rename_in    (rename_in),
        .retire_valid (retire_valid),
        .retire_phys  (retire_phys),
        .new_phys     (new_phys),
        .accept       (accept),
        .rename_stall (rename_stall)
    );

    // unit u completes after u+1 cycles
    for (genvar u = 0; u < fu_count; u++) begin : g_unit
        exec_unit #(
            .latency (u + 1)
        ) u_exec (
            .clock       (clock),
            .reset       (reset),
            .issue_valid (issue_valid[u]),
            .issue_tag   (issue_tag[u]),
            .issue_ready (issue_ready[u]),
            .request     (unit_req[u]),
            .grant       (unit_grant[u])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clock   (clock),
        .reset   (reset),
        .request (unit_req),
        .grant   (unit_grant),
        .cdb     (cdb)
    );

endmodule

//--- test/rename_asserts.sv
`timescale 1ns/1ps

module rename_asserts #(
    parameter bit on_arbiter = 1'b1 // arbiter copy or free list copy
) (
    input logic                                       clock,
    input logic                                       reset,
    input cdb_pkg::cdb_packet [cdb_pkg::fu_count-1:0] request,
    input logic               [cdb_pkg::fu_count-1:0] grant,
    input rename_pkg::free_count                      count
);
    import rename_pkg::*;
    import cdb_pkg::*;

    if (on_arbiter) begin : g_arbiter
        logic [fu_count-1:0] req_valid;

        always_comb begin
            for (int u = 0; u < fu_count; u++) req_valid[u] = request[u].valid;
        end

        grant_needs_request: assert property (@(posedge clock) disable iff (reset)
            (grant & ~req_valid) == '0)
            else $error("arbiter granted a unit that was not requesting");

        two_grants_max: assert property (@(posedge clock) disable iff (reset)
            $countones(grant) <= cdb_lanes)
            else $error("arbiter granted more units than cdb lanes");
    end else begin : g_free_list
        count_in_range: assert property (@(posedge clock) disable iff (reset)
            count <= free_count'(free_regs))
            else $error("free list count went past its capacity");
    end

endmodule

// the side not present in each target is tied off
bind cdb_arbiter rename_asserts #(.on_arbiter(1'b1)) u_arb_asserts (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .grant   (grant),
    .count   ('0)
);

bind free_list rename_asserts #(.on_arbiter(1'b0)) u_free_asserts (
    .clock   (clock),
    .reset   (reset),
    .request ('0),
    .grant   ('0),
    .count   (count)
);

//--- test/rename_checker.sv
`timescale 1ns/1ps

module rename_checker (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  rename_pkg::rename_req   [rename_pkg::rename_width-1:0] rename_in,
    input  logic                    [rename_pkg::rename_width-1:0] retire_valid,
    input  rename_pkg::phys_reg_idx [rename_pkg::rename_width-1:0] retire_phys,
    input  logic                    [cdb_pkg::fu_count-1:0]        issue_valid,
    input  rename_pkg::phys_reg_idx [cdb_pkg::fu_count-1:0]        issue_tag,
    input  rename_pkg::rename_resp  [rename_pkg::rename_width-1:0] rename_out,
    input  logic                                                    rename_stall,
    input  logic                    [cdb_pkg::fu_count-1:0]        issue_ready,
    input  cdb_pkg::cdb_packet      [cdb_pkg::cdb_lanes-1:0]       cdb,
    output int                                                      errors,
    output int                                                      checks,
    output int                                                      inflight
);
    import rename_pkg::*;
    import cdb_pkg::*;

    map_entry [arch_regs-1:0] model_map;
    phys_reg_idx free_q[$];
    phys_reg_idx retire_pending[$];         // reaches the free list a cycle later
    phys_reg_idx unit_q [fu_count][$];      // issued tags per unit, oldest first

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < arch_regs; r++) begin
            model_map[r].phys  = phys_reg_idx'(r);
            model_map[r].ready = 1'b1;
        end
        free_q.delete();
        for (int i = 0; i < free_regs; i++) free_q.push_back(phys_reg_idx'(arch_regs + i));
        retire_pending.delete();
        for (int u = 0; u < fu_count; u++) unit_q[u].delete();
        errors   = 0;
        checks   = 0;
        inflight = 0;
    endtask

    task automatic check_cycle();
        int                  need;
        int                  next;
        logic                accept;
        bit                  found;
        int                  occupancy [fu_count];
        logic [fu_count-1:0] popped;

        // broadcasts wake the entry still mapped to the tag
        for (int c = 0; c < cdb_lanes; c++) begin
            for (int r = 0; r < arch_regs; r++) begin
                if (cdb[c].valid && model_map[r].phys == cdb[c].tag) model_map[r].ready = 1'b1;
            end
        end

        need = 0;
        for (int i = 0; i < rename_width; i++) begin
            if (rename_in[i].valid && rename_in[i].has_dest) need++;
        end
        accept = (free_q.size() >= need);
        compare_value("rename_stall", 32'(!accept), 32'(rename_stall));

        next = 0;
        for (int i = 0; i < rename_width; i++) begin
            compare_value($sformatf("rename_out[%0d].valid", i),
                          32'(rename_in[i].valid && accept), 32'(rename_out[i].valid));
            if (rename_in[i].valid && accept) begin
                compare_value($sformatf("rename_out[%0d].src1_phys", i),
                              32'(model_map[rename_in[i].src1].phys),
                              32'(rename_out[i].src1_phys));
                compare_value($sformatf("rename_out[%0d].src1_ready", i),
                              32'(model_map[rename_in[i].src1].ready),
                              32'(rename_out[i].src1_ready));
                compare_value($sformatf("rename_out[%0d].src2_phys", i),
                              32'(model_map[rename_in[i].src2].phys),
                              32'(rename_out[i].src2_phys));
                compare_value($sformatf("rename_out[%0d].src2_ready", i),
                              32'(model_map[rename_in[i].src2].ready),
                              32'(rename_out[i].src2_ready));
                if (rename_in[i].has_dest) begin
                    compare_value($sformatf("rename_out[%0d].t_old", i),
                                  32'(model_map[rename_in[i].dest].phys),
                                  32'(rename_out[i].t_old));
                    compare_value($sformatf("rename_out[%0d].dest_phys", i),
                                  32'(free_q[next]), 32'(rename_out[i].dest_phys));
                    // later lanes see this mapping
                    model_map[rename_in[i].dest].phys  = free_q[next];
                    model_map[rename_in[i].dest].ready = 1'b0;
                    next++;
                end
            end
        end

        repeat (next) void'(free_q.pop_front());
        foreach (retire_pending[k]) free_q.push_back(retire_pending[k]);
        retire_pending.delete();
        for (int i = 0; i < rename_width; i++) begin
            if (retire_valid[i]) retire_pending.push_back(retire_phys[i]);
        end

        for (int u = 0; u < fu_count; u++) occupancy[u] = unit_q[u].size();
        popped = '0;

        // each broadcast must be the oldest tag of some unit
        for (int c = 0; c < cdb_lanes; c++) begin
            if (cdb[c].valid) begin
                found = 0;
                for (int u = 0; u < fu_count; u++) begin
                    if (!found && unit_q[u].size() > 0 && unit_q[u][0] == cdb[c].tag) begin
                        void'(unit_q[u].pop_front());
                        popped[u] = 1'b1;
                        found = 1;
                    end
                end
                checks++;
                if (!found) begin
                    errors++;
                    $display("cdb lane %0d carried tag %h that is no unit's oldest in-flight tag",
                             c, cdb[c].tag);
                end
            end
        end

        // unit u has u+1 slots and takes a tag when one is free or its head leaves
        for (int u = 0; u < fu_count; u++) begin
            compare_value($sformatf("issue_ready[%0d]", u),
                          32'(occupancy[u] < u + 1 || popped[u]), 32'(issue_ready[u]));
        end

        for (int u = 0; u < fu_count; u++) begin
            if (issue_valid[u] && issue_ready[u]) unit_q[u].push_back(issue_tag[u]);
        end

        inflight = 0;
        for (int u = 0; u < fu_count; u++) inflight += unit_q[u].size();
    endtask

    // inputs change on the rising edge, so the falling edge sees settled values
    always @(negedge clock) begin
        if (reset) begin
            reset_model();
        end else begin
            check_cycle();
        end
    end

endmodule

//--- test/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;
    import cdb_pkg::*;

    localparam int warmup_cycles = 40;   // first groups see the reset map
    localparam int random_cycles = 2000;
    localparam int drain_timeout = 1000;

    logic                           clock;
    logic                           reset;
    rename_req   [rename_width-1:0] rename_in;
    logic        [rename_width-1:0] retire_valid;
    phys_reg_idx [rename_width-1:0] retire_phys;
    logic        [fu_count-1:0]     issue_valid;
    phys_reg_idx [fu_count-1:0]     issue_tag;
    rename_resp  [rename_width-1:0] rename_out;
    logic                           rename_stall;
    logic        [fu_count-1:0]     issue_ready;
    cdb_packet   [cdb_lanes-1:0]    cdb;

    int errors;     // from the checker
    int checks;
    int inflight;
    int own_errors;
    int prev_errors;
    int prev_checks;
    logic verdict_done;

    phys_reg_idx          unissued[$];  // renamed dests waiting for a unit
    phys_reg_idx          retire_q[$];  // t_old tags in program order
    logic [phys_regs-1:0] busy;         // renamed and not yet broadcast
    logic [fu_count-1:0]  held;         // issue offered but not taken

    rename_top DUT (
        .clock        (clock),
        .reset        (reset),
        .rename_in    (rename_in),
        .retire_valid (retire_valid),
        .retire_phys  (retire_phys),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .rename_out   (rename_out),
        .rename_stall (rename_stall),
        .issue_ready  (issue_ready),
        .cdb          (cdb)
    );

    rename_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .rename_in    (rename_in),
        .retire_valid (retire_valid),
        .retire_phys  (retire_phys),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .rename_out   (rename_out),
        .rename_stall (rename_stall),
        .issue_ready  (issue_ready),
        .cdb          (cdb),
        .errors       (errors),
        .checks       (checks),
        .inflight     (inflight)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // bookkeeping from what the DUT handed back this cycle
    task automatic observe_outputs();
        for (int c = 0; c < cdb_lanes; c++) begin
            if (cdb[c].valid) busy[cdb[c].tag] = 1'b0;
        end
        for (int i = 0; i < rename_width; i++) begin
            if (rename_out[i].valid && rename_in[i].has_dest) begin
                busy[rename_out[i].dest_phys] = 1'b1;
                unissued.push_back(rename_out[i].dest_phys);
                retire_q.push_back(rename_out[i].t_old);
            end
        end
        held = issue_valid & ~issue_ready;
    endtask

    task automatic drive_inputs(input bit allow_rename);
        rename_req   [rename_width-1:0] group;
        logic        [rename_width-1:0] rv;
        phys_reg_idx [rename_width-1:0] rp;
        logic        [fu_count-1:0]     iv;
        phys_reg_idx [fu_count-1:0]     it;

        group = '0;
        rv    = '0;
        rp    = '0;
        iv    = issue_valid;
        it    = issue_tag;
        if (allow_rename) begin
            for (int i = 0; i < rename_width; i++) begin
                group[i].valid    = ($urandom_range(3) != 0);
                group[i].has_dest = ($urandom_range(4) != 0);
                group[i].dest     = arch_reg_idx'($urandom);
                group[i].src1     = arch_reg_idx'($urandom);
                group[i].src2     = arch_reg_idx'($urandom);
            end
            if ($urandom_range(3) == 0) group[1].src1 = group[0].dest; // bypass case
            if ($urandom_range(7) == 0) group[1].dest = group[0].dest; // same dest
        end
        // retire in order, only once the tag has completed
        for (int i = 0; i < rename_width; i++) begin
            if ($urandom_range(9) < 6 && retire_q.size() > 0 && !busy[retire_q[0]]) begin
                rv[i] = 1'b1;
                rp[i] = retire_q.pop_front();
            end
        end
        for (int u = 0; u < fu_count; u++) begin
            if (!held[u]) begin
                iv[u] = 1'b0;
                if (unissued.size() > 0 && $urandom_range(9) < 7) begin
                    iv[u] = 1'b1;
                    it[u] = unissued.pop_front();
                end
            end
        end
        rename_in    <= group;
        retire_valid <= rv;
        retire_phys  <= rp;
        issue_valid  <= iv;
        issue_tag    <= it;
    endtask

    task automatic run_cycles(input int n, input bit allow_rename);
        repeat (n) begin
            @(negedge clock);
            observe_outputs();
            @(posedge clock);
            drive_inputs(allow_rename);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished: %0d checks, %0d errors", name,
                 checks - prev_checks, errors - prev_errors);
        prev_checks = checks;
        prev_errors = errors;
    endtask

    initial begin
        int waited;

        void'($urandom(32'ha161));
        reset        = 1'b1;
        rename_in    = '0;
        retire_valid = '0;
        retire_phys  = '0;
        issue_valid  = '0;
        issue_tag    = '0;
        busy         = '0;
        held         = '0;
        own_errors   = 0;
        prev_errors  = 0;
        prev_checks  = 0;
        verdict_done = 1'b0;

        repeat (8) @(posedge clock);
        reset <= 1'b0;

        run_cycles(warmup_cycles, 1'b1);
        report_test("reset_state");
        run_cycles(random_cycles - warmup_cycles, 1'b1);
        report_test("random_traffic");

        // no new groups, let every renamed tag issue and complete
        waited = 0;
        while (busy != '0 && waited < drain_timeout) begin
            run_cycles(1, 1'b0);
            waited++;
        end
        if (busy != '0) begin
            $display("drain timed out with %0d tags never broadcast", $countones(busy));
            own_errors++;
        end
        if (inflight != 0) begin
            $display("checker still holds %0d issued tags that never reached the cdb",
                     inflight);
            own_errors++;
        end
        report_test("drain");

        $display("total: %0d checks, %0d errors", checks, errors + own_errors);
        verdict_done = 1'b1;
        if (errors == 0 && own_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // run stopped before the closing report
    final begin
        if (!verdict_done) $display("Finished with errors");
    end

endmodule

//--- compile.f
hdl/rename_pkg.sv
hdl/cdb_pkg.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/exec_unit.sv
hdl/cdb_arbiter.sv
hdl/rename_top.sv
test/rename_asserts.sv
test/rename_checker.sv
test/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
